//--- list.f
+incdir+tests
design/pong_pkg.sv
design/frame_sequencer.sv
design/paddle_control.sv
design/puck_physics.sv
design/pixel_writer.sv
design/pong_top.sv
tests/pong_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module pong_tb -f list.f -o pong_sim &&
  ./obj_dir/pong_sim > sim.log 2>&1 ||
  echo "build or simulation returned an error"

grep -qs "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -qs "TB PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"

//--- tests/pong_model.svh
// reference model of the game rules, included into the testbench module
// it appends the writes the engine should make to expect_q, in order

// button rule on the last erase write, right wins when both are pressed
function automatic int paddle_rule(int paddle, logic [1:0] buttons);
  if (!buttons[0] && paddle <= RIGHT_LINE - PADDLE_WIDTH - 2) begin
    return paddle + PADDLE_STEP;
  end
  if (!buttons[1] && paddle >= LEFT_LINE + 2) begin
    return paddle - PADDLE_STEP;
  end
  return paddle;
endfunction

task automatic push_write(int px, int py, colour_t pc, bit after_wait);
  expect_t e;
  e.x          = 8'(px);
  e.y          = 7'(py);
  e.colour     = pc;
  e.after_wait = after_wait;
  expect_q.push_back(e);
endtask

// blank screen in raster order, then top, right and left borders
task automatic expect_restart();
  for (int r = 0; r < SCREEN_HEIGHT; r++) begin
    for (int c = 0; c < SCREEN_WIDTH; c++) begin
      push_write(c, r, COLOUR_BACKGROUND, 1'b0);
    end
  end
  for (int c = LEFT_LINE; c <= RIGHT_LINE; c++) begin
    push_write(c, TOP_LINE, COLOUR_BORDER, 1'b0);
  end
  for (int r = TOP_LINE; r < SCREEN_HEIGHT; r++) begin
    push_write(RIGHT_LINE, r, COLOUR_BORDER, 1'b0);
  end
  for (int r = TOP_LINE; r < SCREEN_HEIGHT; r++) begin
    push_write(LEFT_LINE, r, COLOUR_BORDER, 1'b0);
  end
  // every sprite goes back to its start after a clear
  model_paddle = PADDLE_X_START;
  puck_x       = FACEOFF_X;
  puck_y       = FACEOFF_Y;
  step_x       = int'($signed(VELOCITY_START_X));
  step_y       = int'($signed(VELOCITY_START_Y));
endtask

// one frame of play, the first paddle erase write follows the idle gap
task automatic expect_frame(logic [1:0] buttons);
  int next_x;
  int next_y;
  for (int i = 0; i <= PADDLE_WIDTH; i++) begin
    push_write(model_paddle + i, PADDLE_ROW, COLOUR_BACKGROUND, i == 0);
  end
  model_paddle = paddle_rule(model_paddle, buttons);
  for (int i = 0; i <= PADDLE_WIDTH; i++) begin
    push_write(model_paddle + i, PADDLE_ROW, COLOUR_SPRITE, 1'b0);
  end
  push_write(puck_x, puck_y, COLOUR_BACKGROUND, 1'b0);
  next_x = puck_x + step_x;
  next_y = puck_y + step_y;
  // bounces are decided on the position the puck moves to
  if (next_y == TOP_LINE + 1) begin
    step_y = -step_y;
  end
  if (next_x == LEFT_LINE + 1 || next_x == RIGHT_LINE - 1) begin
    step_x = -step_x;
  end
  puck_x = next_x;
  puck_y = next_y;
  if (next_y == PADDLE_ROW - 1) begin
    if (next_x >= model_paddle && next_x <= model_paddle + PADDLE_WIDTH) begin
      step_y = -step_y;
    end else begin
      // a miss skips the puck draw and starts over from a clear
      expect_restart();
      return;
    end
  end
  push_write(puck_x, puck_y, COLOUR_SPRITE, 1'b0);
endtask

//--- tests/pong_tb.sv
`timescale 1ns/1ps

module pong_tb import pong_pkg::*; ();

  localparam int LOOP_CYCLES  = 4;
  localparam int CLOCK_PERIOD = 20;
  localparam int NUM_ROWS     = 7;

  // one frame is the idle gap, two paddle spans and two puck writes, with slack
  localparam int FRAME_CYCLES = LOOP_CYCLES + 2 * (PADDLE_WIDTH + 1) + 4;
  // a full clear together with its three border lines
  localparam int CLEAR_CYCLES = SCREEN_WIDTH * SCREEN_HEIGHT + (RIGHT_LINE - LEFT_LINE + 1) +
                                2 * (SCREEN_HEIGHT - TOP_LINE) + 4;

  // one expected write, after_wait marks the first write behind the idle gap
  typedef struct packed {
    logic [7:0] x;
    logic [6:0] y;
    colour_t    colour;
    logic       after_wait;
  } expect_t;

  // buttons are KEY[1:0] as driven, active low
  typedef struct {
    logic [1:0] buttons;
    bit         random;
    int         frames;
    int         paddle_after;
    string      name;
  } row_t;

  // ==============================
  // stimulus table
  // ==============================

  // paddle_after is the left end of the last paddle drawn in the row, -1 skips it
  // the paddle_hit row parks the paddle under the puck, the idle row after it lets the puck miss
  row_t rows [NUM_ROWS] = '{
    '{2'b11, 1'b0, 4,   76,  "idle_start"},
    '{2'b00, 1'b0, 4,   84,  "both_buttons"},
    '{2'b01, 1'b0, 41,  6,   "left_clamp"},
    '{2'b10, 1'b0, 71,  146, "right_clamp"},
    '{2'b01, 1'b0, 42,  62,  "paddle_hit"},
    '{2'b11, 1'b0, 217, 76,  "miss_restart"},
    '{2'b11, 1'b1, 20,  -1,  "random_buttons"}
  };

  logic        CLOCK_50 = 1'b0;
  logic [3:0]  KEY;
  logic [7:0]  x;
  logic [6:0]  y;
  logic [2:0]  colour;
  logic        plot;

  expect_t     expect_q[$];
  logic [31:0] lfsr_state;
  string       current_test;
  int          idle_cycles    = 0;
  int          drawn_paddle_x = -1;
  bit          in_paddle_span = 1'b0;

  // model state of the paddle and the puck
  int          model_paddle;
  int          puck_x;
  int          puck_y;
  int          step_x;
  int          step_y;

  `include "pong_model.svh"

  pong_top #(
    .LOOP_CYCLES(LOOP_CYCLES)
  ) i_dut (
    .CLOCK_50(CLOCK_50),
    .KEY     (KEY),
    .x       (x),
    .y       (y),
    .colour  (colour),
    .plot    (plot)
  );

  always #(CLOCK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
  function automatic bit lfsr_bit();
    bit feedback;
    feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], feedback};
    return feedback;
  endfunction

  function automatic string pixel_text(logic [7:0] px, logic [6:0] py, logic [2:0] pc);
    return $sformatf("x %0d y %0d colour %0d", px, py, pc);
  endfunction

  task automatic value_error(string what, string expected, string actual);
    $display("Error: test %s, %s expected %s, actual %s", current_test, what, expected, actual);
    $display("TB FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic stop_run(string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  // ==============================
  // write stream checker
  // ==============================

  // outputs change on the rising edge, so the values seen here are the settled ones
  always @(posedge CLOCK_50) begin : check_writes
    expect_t want;
    if (!KEY[3]) begin
      assert (!plot) else stop_run("plot was high while reset was held");
      idle_cycles = 0;
    end else if (!plot) begin
      idle_cycles = idle_cycles + 1;
    end else begin
      assert (expect_q.size() != 0) else stop_run("the DUT wrote a pixel the model did not expect");
      want = expect_q.pop_front();
      assert ({x, y, colour} == {want.x, want.y, want.colour}) else begin
        value_error("pixel", pixel_text(want.x, want.y, want.colour), pixel_text(x, y, colour));
      end
      if (want.after_wait) begin
        assert (idle_cycles == LOOP_CYCLES) else begin
          value_error("idle cycles", $sformatf("%0d", LOOP_CYCLES), $sformatf("%0d", idle_cycles));
        end
      end
      // remember where each sprite span on the paddle row starts
      if (colour == COLOUR_SPRITE && int'(y) == PADDLE_ROW) begin
        if (!in_paddle_span) begin
          drawn_paddle_x = int'(x);
        end
        in_paddle_span = 1'b1;
      end else begin
        in_paddle_span = 1'b0;
      end
      idle_cycles = 0;
    end
  end

  // ==============================
  // stimulus
  // ==============================

  initial begin : stimulus
    logic [1:0] buttons;
    KEY          = 4'b0111;
    lfsr_state   = 32'ha8c50cb4;
    current_test = "reset_clear";
    expect_restart();
    repeat (8) @(negedge CLOCK_50);
    KEY[3] = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int f = 0; f < rows[r].frames; f++) begin
        // buttons change only in the idle gap, once the previous frame is fully written
        while (expect_q.size() != 0) begin
          @(negedge CLOCK_50);
        end
        current_test = rows[r].name;
        buttons      = rows[r].buttons;
        if (rows[r].random) begin
          buttons[0] = lfsr_bit();
          buttons[1] = lfsr_bit();
        end
        KEY[1:0] = buttons;
        expect_frame(buttons);
      end
      while (expect_q.size() != 0) begin
        @(negedge CLOCK_50);
      end
      if (rows[r].paddle_after >= 0) begin
        assert (drawn_paddle_x == rows[r].paddle_after) else begin
          value_error("paddle position", $sformatf("%0d", rows[r].paddle_after),
                      $sformatf("%0d", drawn_paddle_x));
        end
      end
    end
    $display("TB PASSED");
    $finish;
  end

  // the limit covers every table frame plus the first clear and one restart
  initial begin : watchdog
    int total_frames;
    total_frames = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total_frames = total_frames + rows[r].frames;
    end
    #((total_frames * FRAME_CYCLES + 2 * CLEAR_CYCLES) * CLOCK_PERIOD);
    stop_run("watchdog expired before the DUT made all expected writes");
  end

endmodule

//--- design/pong_top.sv
`timescale 1ns/1ps

module pong_top import pong_pkg::*; #(
  // idle cycles between frames, one eighth of a second at 50 MHz
  parameter int LOOP_CYCLES = 6250000
) (
  input  logic       CLOCK_50,
  input  logic [3:0] KEY,
  output logic [7:0] x,
  output logic [6:0] y,
  output logic [2:0] colour,
  output logic       plot
);

  // phase of the game, shared by every block
  phase_t phase;

  // handshakes between the blocks
  logic   scan_done;
  logic   miss;

  // positions of the two sprites
  coord_t paddle_x;
  point_t puck;

  // the registered write from the pixel writer
  pixel_t write;

  frame_sequencer #(
    .LOOP_CYCLES(LOOP_CYCLES)
  ) i_frame_sequencer (
    .CLOCK_50 (CLOCK_50),
    .KEY      (KEY[3]),
    .scan_done(scan_done),
    .miss     (miss),
    .phase    (phase)
  );

  // the whole key bank goes in since the paddle reads the buttons and the reset
  paddle_control i_paddle_control (
    .CLOCK_50 (CLOCK_50),
    .KEY      (KEY),
    .phase    (phase),
    .scan_done(scan_done),
    .paddle_x (paddle_x)
  );

  puck_physics i_puck_physics (
    .CLOCK_50(CLOCK_50),
    .KEY     (KEY[3]),
    .phase   (phase),
    .paddle_x(paddle_x),
    .puck    (puck),
    .miss    (miss)
  );

  pixel_writer i_pixel_writer (
    .CLOCK_50 (CLOCK_50),
    .KEY      (KEY[3]),
    .phase    (phase),
    .paddle_x (paddle_x),
    .puck     (puck),
    .pixel    (write),
    .plot     (plot),
    .scan_done(scan_done)
  );

  // the frame buffer is only 120 rows high, so the top bit of y is always zero
  assign x      = write.point.x;
  assign y      = write.point.y[6:0];
  assign colour = write.colour;

endmodule

//--- design/pixel_writer.sv
`timescale 1ns/1ps

module pixel_writer import pong_pkg::*; (
  input  logic   CLOCK_50,
  input  logic   KEY,
  input  phase_t phase,
  input  coord_t paddle_x,
  input  point_t puck,
  output pixel_t pixel,
  output logic   plot,
  output logic   scan_done
);

  // scan position inside the current phase with x running fastest
  coord_t cnt_x;
  coord_t cnt_y;

  // last counter values of the current scan
  coord_t x_last;
  coord_t y_last;

  // scanning phases walk the counters and active phases write a pixel
  logic   scanning;
  logic   active;
  pixel_t pixel_next;

  // ==============================
  // phase decode
  // ==============================

  always_comb begin
    x_last     = '0;
    y_last     = '0;
    scanning   = 1'b1;
    active     = 1'b1;
    pixel_next = '{point: puck, colour: COLOUR_BLACK};
    case (phase)
      PHASE_CLEAR: begin
        // the whole frame in raster order
        x_last                 = coord_t'(SCREEN_WIDTH - 1);
        y_last                 = coord_t'(SCREEN_HEIGHT - 1);
        pixel_next.point       = '{x: cnt_x, y: cnt_y};
        pixel_next.colour      = COLOUR_BACKGROUND;
      end
      PHASE_BORDER_TOP: begin
        // one row from the left line across to the right line
        x_last                 = coord_t'(RIGHT_LINE - LEFT_LINE);
        pixel_next.point.x     = coord_t'(LEFT_LINE) + cnt_x;
        pixel_next.point.y     = coord_t'(TOP_LINE);
        pixel_next.colour      = COLOUR_BORDER;
      end
      PHASE_BORDER_RIGHT: begin
        // with x_last at zero every step moves down one row
        y_last                 = coord_t'(SCREEN_HEIGHT - 1 - TOP_LINE);
        pixel_next.point.x     = coord_t'(RIGHT_LINE);
        pixel_next.point.y     = coord_t'(TOP_LINE) + cnt_y;
        pixel_next.colour      = COLOUR_BORDER;
      end
      PHASE_BORDER_LEFT: begin
        y_last                 = coord_t'(SCREEN_HEIGHT - 1 - TOP_LINE);
        pixel_next.point.x     = coord_t'(LEFT_LINE);
        pixel_next.point.y     = coord_t'(TOP_LINE) + cnt_y;
        pixel_next.colour      = COLOUR_BORDER;
      end
      PHASE_ERASE_PADDLE, PHASE_DRAW_PADDLE: begin
        // both spans cover PADDLE_WIDTH+1 pixels from the current paddle_x
        x_last                 = coord_t'(PADDLE_WIDTH);
        pixel_next.point.x     = paddle_x + cnt_x;
        pixel_next.point.y     = coord_t'(PADDLE_ROW);
        pixel_next.colour      = (phase == PHASE_ERASE_PADDLE) ?
                                 COLOUR_BACKGROUND : COLOUR_SPRITE;
      end
      PHASE_ERASE_PUCK: begin
        // single write at the puck position without a scan
        scanning               = 1'b0;
        pixel_next.colour      = COLOUR_BACKGROUND;
      end
      PHASE_DRAW_PUCK: begin
        scanning               = 1'b0;
        pixel_next.colour      = COLOUR_SPRITE;
      end
      default: begin
        // nothing is written in the wait phase
        scanning               = 1'b0;
        active                 = 1'b0;
      end
    endcase
  end

  // flags the cycle that selects the final pixel of a scan
  assign scan_done = scanning && (cnt_x == x_last) && (cnt_y == y_last);

  // ==============================
  // scan counters
  // ==============================

  always_ff @(posedge CLOCK_50, negedge KEY) begin
    if (!KEY) begin
      cnt_x <= '0;
      cnt_y <= '0;
    end else if (!scanning || scan_done) begin
      // park at zero so the next scan starts at its first pixel
      cnt_x <= '0;
      cnt_y <= '0;
    end else if (cnt_x == x_last) begin
      cnt_x <= '0;
      cnt_y <= cnt_y + 1'b1;
    end else begin
      cnt_x <= cnt_x + 1'b1;
    end
  end

  // ==============================
  // write register
  // ==============================

  // plot is registered next to the write so both reach the outputs in the same cycle
  always_ff @(posedge CLOCK_50, negedge KEY) begin
    if (!KEY) begin
      plot <= 1'b0;
    end else begin
      plot <= active;
    end
  end

  // the pixel chosen by the phase decode leaves one cycle later
  always_ff @(posedge CLOCK_50) begin
    pixel <= pixel_next;
  end

endmodule

//--- design/puck_physics.sv
`timescale 1ns/1ps

module puck_physics import pong_pkg::*; (
  input  logic   CLOCK_50,
  input  logic   KEY,
  input  phase_t phase,
  input  coord_t paddle_x,
  output point_t puck,
  output logic   miss
);

  velocity_t velocity;
  point_t    puck_next;
  velocity_t velocity_next;
  logic      at_paddle_row;
  logic      on_paddle;

  // ==============================
  // next position and bounces
  // ==============================

  // velocity fields are +1 or -1 so a wrapping add steps either way
  assign puck_next.x = puck.x + velocity.x;
  assign puck_next.y = puck.y + velocity.y;

  assign at_paddle_row = (puck_next.y == coord_t'(PADDLE_ROW - 1));

  // the paddle covers paddle_x up to paddle_x+PADDLE_WIDTH, both ends included
  assign on_paddle = (puck_next.x >= paddle_x) &&
                     (puck_next.x <= paddle_x + coord_t'(PADDLE_WIDTH));

  always_comb begin
    velocity_next = velocity;
    // bounce off the top border
    if (puck_next.y == coord_t'(TOP_LINE + 1)) begin
      velocity_next.y = 8'd0 - velocity.y;
    end
    // bounce off either side border
    if (puck_next.x == coord_t'(LEFT_LINE + 1) ||
        puck_next.x == coord_t'(RIGHT_LINE - 1)) begin
      velocity_next.x = 8'd0 - velocity.x;
    end
    // bounce off the paddle, a miss is flagged separately below
    if (at_paddle_row && on_paddle) begin
      velocity_next.y = 8'd0 - velocity.y;
    end
  end

  // only meaningful in the single erase cycle, where the sequencer looks at it
  assign miss = (phase == PHASE_ERASE_PUCK) && at_paddle_row && !on_paddle;

  // ==============================
  // puck registers
  // ==============================

  always_ff @(posedge CLOCK_50, negedge KEY) begin
    if (!KEY) begin
      puck       <= '{x: coord_t'(FACEOFF_X), y: coord_t'(FACEOFF_Y)};
      velocity   <= '{x: VELOCITY_START_X, y: VELOCITY_START_Y};
    end else if (phase == PHASE_CLEAR) begin
      // a new game faces off from the centre again
      puck       <= '{x: coord_t'(FACEOFF_X), y: coord_t'(FACEOFF_Y)};
      velocity   <= '{x: VELOCITY_START_X, y: VELOCITY_START_Y};
    end else if (phase == PHASE_ERASE_PUCK) begin
      // the erase write still uses the old position in this cycle
      puck       <= puck_next;
      velocity   <= velocity_next;
    end
  end

endmodule

//--- design/paddle_control.sv
`timescale 1ns/1ps

module paddle_control import pong_pkg::*; (
  input  logic       CLOCK_50,
  input  logic [3:0] KEY,
  input  phase_t     phase,
  input  logic       scan_done,
  output coord_t     paddle_x
);

  // buttons are active low
  logic move_right;
  logic move_left;
  logic update;

  // right only when there is still room before the right border
  assign move_right = !KEY[0] &&
                      (paddle_x <= coord_t'(RIGHT_LINE - PADDLE_WIDTH - 2));

  // left only when there is still room after the left border
  assign move_left  = !KEY[1] && (paddle_x >= coord_t'(LEFT_LINE + 2));

  // the move lands on the last erase write, so the draw span
  // that follows already sees the new position
  assign update = (phase == PHASE_ERASE_PADDLE) && scan_done;

  always_ff @(posedge CLOCK_50, negedge KEY[3]) begin
    if (!KEY[3]) begin
      paddle_x <= coord_t'(PADDLE_X_START);
    end else if (phase == PHASE_CLEAR) begin
      // every new game starts with the paddle centred
      paddle_x <= coord_t'(PADDLE_X_START);
    end else if (update) begin
      // right wins when both moves are allowed
      if (move_right) begin
        paddle_x <= paddle_x + coord_t'(PADDLE_STEP);
      end else if (move_left) begin
        paddle_x <= paddle_x - coord_t'(PADDLE_STEP);
      end
    end
  end

endmodule

//--- design/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer import pong_pkg::*; #(
  parameter int LOOP_CYCLES = 6250000
) (
  input  logic   CLOCK_50,
  input  logic   KEY,
  input  logic   scan_done,
  input  logic   miss,
  output phase_t phase
);

  // the wait counter only has to reach LOOP_CYCLES-1
  localparam int CNT_W = (LOOP_CYCLES > 1) ? $clog2(LOOP_CYCLES) : 1;

  logic [CNT_W-1:0] wait_count;
  logic             wait_done;
  phase_t           phase_next;

  // ==============================
  // inter-frame delay
  // ==============================

  // the last wait cycle is the one where the counter hits LOOP_CYCLES-1
  assign wait_done = (wait_count == CNT_W'(LOOP_CYCLES - 1));

  always_ff @(posedge CLOCK_50, negedge KEY) begin
    if (!KEY) begin
      wait_count <= '0;
    end else if (phase == PHASE_WAIT && !wait_done) begin
      wait_count <= wait_count + 1'b1;
    end else begin
      // any other phase keeps the counter parked at zero for the next frame
      wait_count <= '0;
    end
  end

  // ==============================
  // phase order
  // ==============================

  always_comb begin
    phase_next = phase;
    case (phase)
      // the scanned phases move on once the pixel writer issues its last write
      PHASE_CLEAR: begin
        if (scan_done) phase_next = PHASE_BORDER_TOP;
      end
      PHASE_BORDER_TOP: begin
        if (scan_done) phase_next = PHASE_BORDER_RIGHT;
      end
      PHASE_BORDER_RIGHT: begin
        if (scan_done) phase_next = PHASE_BORDER_LEFT;
      end
      PHASE_BORDER_LEFT: begin
        if (scan_done) phase_next = PHASE_WAIT;
      end
      PHASE_WAIT: begin
        if (wait_done) phase_next = PHASE_ERASE_PADDLE;
      end
      PHASE_ERASE_PADDLE: begin
        if (scan_done) phase_next = PHASE_DRAW_PADDLE;
      end
      PHASE_DRAW_PADDLE: begin
        if (scan_done) phase_next = PHASE_ERASE_PUCK;
      end
      // the puck phases last one cycle each
      // a miss skips the draw and restarts the game from a blank screen
      PHASE_ERASE_PUCK: begin
        phase_next = miss ? PHASE_CLEAR : PHASE_DRAW_PUCK;
      end
      PHASE_DRAW_PUCK: begin
        phase_next = PHASE_WAIT;
      end
      default: begin
        phase_next = PHASE_CLEAR;
      end
    endcase
  end

  always_ff @(posedge CLOCK_50, negedge KEY) begin
    if (!KEY) begin
      phase <= PHASE_CLEAR;
    end else begin
      phase <= phase_next;
    end
  end

endmodule

//--- design/pong_pkg.sv
package pong_pkg;

  // ==============================
  // basic types
  // ==============================

  // one screen coordinate, wide enough for the 160 pixel row
  typedef logic [7:0] coord_t;

  // a location on the screen
  typedef struct packed {
    coord_t x;
    coord_t y;
  } point_t;

  // per-frame step of the puck, each field holds +1 or -1 in two's complement
  // so that a plain coord_t add moves the puck either way
  typedef struct packed {
    coord_t x;
    coord_t y;
  } velocity_t;

  // colour bits are red, green, blue from msb to lsb
  typedef enum logic [2:0] {
    COLOUR_BLACK      = 3'b000,
    COLOUR_BACKGROUND = 3'b110,
    COLOUR_BORDER     = 3'b111,
    COLOUR_SPRITE     = 3'b101
  } colour_t;

  // one write towards the frame buffer
  typedef struct packed {
    point_t  point;
    colour_t colour;
  } pixel_t;

  // the phases of the game, in the order the sequencer walks through them
  typedef enum logic [3:0] {
    PHASE_CLEAR,
    PHASE_BORDER_TOP,
    PHASE_BORDER_RIGHT,
    PHASE_BORDER_LEFT,
    PHASE_WAIT,
    PHASE_ERASE_PADDLE,
    PHASE_DRAW_PADDLE,
    PHASE_ERASE_PUCK,
    PHASE_DRAW_PUCK
  } phase_t;

  // ==============================
  // screen geometry
  // ==============================

  localparam int SCREEN_WIDTH  = 160;
  localparam int SCREEN_HEIGHT = 120;

  // the three border lines that fence the playing field
  localparam int LEFT_LINE  = 5;
  localparam int RIGHT_LINE = 155;
  localparam int TOP_LINE   = 5;

  // the paddle spans PADDLE_WIDTH+1 pixels starting at its x position
  localparam int PADDLE_ROW     = 115;
  localparam int PADDLE_WIDTH   = 8;
  localparam int PADDLE_X_START = 76;
  localparam int PADDLE_STEP    = 2;

  // where the puck starts after every clear
  localparam int FACEOFF_X = 80;
  localparam int FACEOFF_Y = 60;

  // the puck starts moving right and up
  localparam coord_t VELOCITY_START_X = 8'h01;
  localparam coord_t VELOCITY_START_Y = 8'hff;

endpackage
